/* design/aes_defines.svh */
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// bus word and cipher word width
`define AES_WORD_W 32

// words per block and per round key
`define AES_NB 4

// rounds after the initial key addition
`define AES_ROUNDS 10

// progress counter
`define CTR_W 16

// counter value once the last round has been written
`define SEQ_DONE_COUNT 43

// address bits that pick a register word
`define MMIO_IDX_MSB 6
`define MMIO_IDX_LSB 2

`endif

/* design/aesPkg.sv */
`include "aes_defines.svh"

package aesPkg;

	typedef logic [`AES_WORD_W-1:0] word_t;

	// word 0 sits in the top bits
	typedef logic [`AES_NB*`AES_WORD_W-1:0] block_t;

	typedef enum logic [1:0] {
		phIdle,
		phLoad,
		phRun,
		phDone
	} seqPhase_e;

	localparam logic [7:0] sboxTable [0:255] = '{
		8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
		8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
		8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
		8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
		8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
		8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
		8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
		8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
		8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
		8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
		8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
		8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
		8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
		8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
		8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
		8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
		8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
		8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
		8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
		8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
		8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
		8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
		8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
		8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
		8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
		8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
		8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
		8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
		8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
		8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
		8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
		8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
	};

	function automatic logic [7:0] sbox(logic [7:0] b);
		return sboxTable[b];
	endfunction

	function automatic word_t subWord(word_t w);
		return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
	endfunction

	function automatic word_t rotWord(word_t w);
		return {w[23:0], w[31:24]};
	endfunction

	// multiply by x, reduced by 0x11b
	function automatic logic [7:0] xtime(logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// 2a^3b^c^d written as a^t^2(a^b), t the xor of all four bytes
	function automatic word_t mixColumn(word_t w);
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		logic [7:0] t;
		a0 = w[31:24];
		a1 = w[23:16];
		a2 = w[15:8];
		a3 = w[7:0];
		t = a0 ^ a1 ^ a2 ^ a3;
		return {a0 ^ t ^ xtime(a0 ^ a1), a1 ^ t ^ xtime(a1 ^ a2),
			a2 ^ t ^ xtime(a2 ^ a3), a3 ^ t ^ xtime(a3 ^ a0)};
	endfunction

endpackage

/* design/mmioPkg.sv */
`include "aes_defines.svh"

package mmioPkg;

	// word index taken from the byte address
	typedef logic [`MMIO_IDX_MSB-`MMIO_IDX_LSB:0] regIdx_t;

	// first word of each register region
	typedef enum regIdx_t {
		regCtrl = 5'd8,
		regCount = 5'd9,
		regKey0 = 5'd10,
		regPt0 = 5'd14,
		regCt0 = 5'd18
	} regOffset_e;

endpackage

/* design/aesMmioRegs.sv */
`timescale 1ns/1ps
`include "aes_defines.svh"

module aesMmioRegs (
	input logic clk,
	input logic rst_n,
	input logic [31:0] addr,
	input logic wrEn,
	input logic accelSelect,
	input aesPkg::word_t dataIn,
	input logic [`CTR_W-1:0] count,
	input logic done,
	input aesPkg::block_t ctOut,
	output aesPkg::block_t keyIn,
	output aesPkg::block_t ptIn,
	output logic goPulse,
	output aesPkg::word_t dataOut
);
	import aesPkg::*;
	import mmioPkg::*;

	regIdx_t idx;
	regOffset_e region;
	logic hit;
	logic [1:0] wordSel;
	logic wrStrobe;
	logic goBit;
	word_t keyWords [`AES_NB];
	word_t ptWords [`AES_NB];

	assign idx = addr[`MMIO_IDX_MSB:`MMIO_IDX_LSB];
	assign wrStrobe = wrEn & accelSelect;

	// region decode, wordSel is the offset inside a four-word region
	always_comb begin
		hit = 1'b1;
		region = regCtrl;
		if (idx == regCount) begin
			region = regCount;
		end else if (idx >= regKey0 && idx < regPt0) begin
			region = regKey0;
		end else if (idx >= regPt0 && idx < regCt0) begin
			region = regPt0;
		end else if (idx >= regCt0 && idx < regCt0 + `AES_NB) begin
			region = regCt0;
		end else if (idx != regCtrl) begin
			hit = 1'b0;
		end
	end

	assign wordSel = 2'(idx - region);

	// any write to the control word starts a run
	assign goPulse = wrStrobe && hit && (region == regCtrl);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			keyWords <= '{default: '0};
			ptWords <= '{default: '0};
			goBit <= 1'b0;
		end else begin
			goBit <= goPulse;
			if (wrStrobe && hit && region == regKey0) begin
				keyWords[wordSel] <= dataIn;
			end
			if (wrStrobe && hit && region == regPt0) begin
				ptWords[wordSel] <= dataIn;
			end
		end
	end

	assign keyIn = {keyWords[0], keyWords[1], keyWords[2], keyWords[3]};
	assign ptIn = {ptWords[0], ptWords[1], ptWords[2], ptWords[3]};

	always_comb begin
		dataOut = '0;
		if (hit) begin
			case (region)
				regCtrl: dataOut = {done, {(`AES_WORD_W-2){1'b0}}, goBit};
				regCount: dataOut = word_t'(count);
				regKey0: dataOut = keyWords[wordSel];
				regPt0: dataOut = ptWords[wordSel];
				regCt0: dataOut = ctOut[(`AES_NB-1-wordSel)*`AES_WORD_W +: `AES_WORD_W];
				default: dataOut = '0;
			endcase
		end
	end

	// a go comes from a bus write and restarts the sequencer at 1
	goFromWrite: assert property (@(posedge clk) disable iff (!rst_n)
		goPulse |-> wrEn ##1 (goBit && count == 1));

endmodule

/* design/aesSequencer.sv */
`timescale 1ns/1ps
`include "aes_defines.svh"

module aesSequencer (
	input logic clk,
	input logic rst_n,
	input logic goPulse,
	output logic [`CTR_W-1:0] count,
	output aesPkg::seqPhase_e phase,
	output logic done
);
	import aesPkg::*;

	logic atEnd;

	assign atEnd = (count == `SEQ_DONE_COUNT);

	// idle at 0, parked at the terminal count
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (goPulse) begin
			count <= `CTR_W'(1);
		end else if (count != '0 && !atEnd) begin
			count <= count + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else begin
			done <= goPulse ? 1'b0 : atEnd;
		end
	end

	always_comb begin
		if (count == '0) begin
			phase = phIdle;
		end else if (count == `CTR_W'(1)) begin
			phase = phLoad;
		end else if (atEnd) begin
			phase = phDone;
		end else begin
			phase = phRun;
		end
	end

	countBound: assert property (@(posedge clk) disable iff (!rst_n)
		count <= `SEQ_DONE_COUNT);

	doneTrack: assert property (@(posedge clk) disable iff (!rst_n)
		done == $past(atEnd && !goPulse));

endmodule

/* design/aesKeySchedule.sv */
`timescale 1ns/1ps
`include "aes_defines.svh"

module aesKeySchedule (
	input logic clk,
	input logic rst_n,
	input aesPkg::seqPhase_e phase,
	input logic [1:0] step,
	input aesPkg::block_t keyIn,
	output aesPkg::block_t roundKey
);
	import aesPkg::*;

	// win[0] is the oldest word
	word_t win [`AES_NB];
	logic [7:0] rcon;
	word_t nextWord;

	// step 2 starts a new round key, so the first word gets the g function
	always_comb begin
		if (step == 2'd2) begin
			nextWord = win[0] ^ subWord(rotWord(win[3])) ^ {rcon, 24'h000000};
		end else begin
			nextWord = win[0] ^ win[3];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			win <= '{default: '0};
			rcon <= 8'h00;
		end else if (phase == phLoad) begin
			for (int k = 0; k < `AES_NB; k++) begin
				win[k] <= keyIn[(`AES_NB-1-k)*`AES_WORD_W +: `AES_WORD_W];
			end
			rcon <= 8'h01;
		end else if (phase == phRun) begin
			for (int k = 0; k < `AES_NB-1; k++) begin
				win[k] <= win[k+1];
			end
			win[`AES_NB-1] <= nextWord;
			// ready for the next step 2
			if (step == 2'd1) begin
				rcon <= xtime(rcon);
			end
		end
	end

	assign roundKey = {win[0], win[1], win[2], win[3]};

endmodule

/* design/aesRoundUnit.sv */
`timescale 1ns/1ps
`include "aes_defines.svh"

module aesRoundUnit (
	input logic clk,
	input logic rst_n,
	input aesPkg::seqPhase_e phase,
	input logic [`CTR_W-1:0] count,
	input aesPkg::block_t ptIn,
	input aesPkg::block_t roundKey,
	output aesPkg::block_t ctOut
);
	import aesPkg::*;

	block_t state;
	block_t shifted;
	block_t mixed;
	block_t nextState;
	logic [`CTR_W-3:0] round;

	// SubBytes and ShiftRows together, row r of column c comes from column c+r
	function automatic block_t subShift(block_t s);
		block_t r;
		int src;
		int dst;
		r = '0;
		for (int c = 0; c < `AES_NB; c++) begin
			for (int row = 0; row < 4; row++) begin
				src = $bits(block_t) - 1 - ((c + row) % `AES_NB) * `AES_WORD_W - row * 8;
				dst = $bits(block_t) - 1 - c * `AES_WORD_W - row * 8;
				r[dst -: 8] = sbox(s[src -: 8]);
			end
		end
		return r;
	endfunction

	assign round = count[`CTR_W-1:2];

	always_comb begin
		shifted = subShift(state);
		for (int c = 0; c < `AES_NB; c++) begin
			mixed[c*`AES_WORD_W +: `AES_WORD_W] = mixColumn(shifted[c*`AES_WORD_W +: `AES_WORD_W]);
		end
		if (round == '0) begin
			nextState = ptIn ^ roundKey;
		end else if (round < `AES_ROUNDS) begin
			nextState = mixed ^ roundKey;
		end else begin
			// last round has no MixColumns
			nextState = shifted ^ roundKey;
		end
	end

	// one round per four counts, on step 2 when the key window is complete
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= '0;
		end else if (phase == phRun && count[1:0] == 2'd2) begin
			state <= nextState;
		end
	end

	assign ctOut = state;

endmodule

/* design/aesAccelerator.sv */
`timescale 1ns/1ps
`include "aes_defines.svh"

module aesAccelerator (
	input logic clk,
	input logic rst_n,
	input logic [31:0] addr,
	input logic wrEn,
	input logic accelSelect,
	input aesPkg::word_t dataIn,
	output aesPkg::word_t dataOut,
	output logic [`CTR_W-1:0] ctr
);
	import aesPkg::*;

	block_t keyIn;
	block_t ptIn;
	block_t ctOut;
	block_t roundKey;
	logic goPulse;
	logic done;
	logic [`CTR_W-1:0] count;
	seqPhase_e phase;

	aesMmioRegs regs (
		.clk(clk),
		.rst_n(rst_n),
		.addr(addr),
		.wrEn(wrEn),
		.accelSelect(accelSelect),
		.dataIn(dataIn),
		.count(count),
		.done(done),
		.ctOut(ctOut),
		.keyIn(keyIn),
		.ptIn(ptIn),
		.goPulse(goPulse),
		.dataOut(dataOut)
	);

	aesSequencer seq (
		.clk(clk),
		.rst_n(rst_n),
		.goPulse(goPulse),
		.count(count),
		.phase(phase),
		.done(done)
	);

	// key window advances on the low count bits
	aesKeySchedule keySched (
		.clk(clk),
		.rst_n(rst_n),
		.phase(phase),
		.step(count[1:0]),
		.keyIn(keyIn),
		.roundKey(roundKey)
	);

	aesRoundUnit roundUnit (
		.clk(clk),
		.rst_n(rst_n),
		.phase(phase),
		.count(count),
		.ptIn(ptIn),
		.roundKey(roundKey),
		.ctOut(ctOut)
	);

	assign ctr = count;

endmodule

/* test/aesAcceleratorTb.sv */
`timescale 1ns/1ps
`include "aes_defines.svh"

module aesAcceleratorTb;
	import mmioPkg::*;

	localparam int NVEC = 3;
	localparam int WATCHDOG_CYCLES = (NVEC + 2) * 100;

	logic clk;
	logic rst_n;
	logic [31:0] addr;
	logic wrEn;
	logic accelSelect;
	logic [31:0] dataIn;
	logic [31:0] dataOut;
	logic [`CTR_W-1:0] ctr;

	logic [127:0] keyTab [NVEC];
	logic [127:0] ptTab [NVEC];
	logic [127:0] ctTab [NVEC];

	// rising edges seen so far, and the edge that takes the last write
	int edgeCount = 0;
	int writeEdge = 0;

	aesAccelerator uut (
		.clk(clk),
		.rst_n(rst_n),
		.addr(addr),
		.wrEn(wrEn),
		.accelSelect(accelSelect),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.ctr(ctr)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		edgeCount <= edgeCount + 1;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s expected %h actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	// all bus tasks start and end on a falling edge
	task automatic busWrite(int idx, logic [31:0] data, logic sel);
		addr = 32'(idx) << 2;
		dataIn = data;
		wrEn = 1'b1;
		accelSelect = sel;
		writeEdge = edgeCount + 1;
		@(negedge clk);
		wrEn = 1'b0;
		accelSelect = 1'b0;
	endtask

	task automatic busRead(int idx, output logic [31:0] data);
		addr = 32'(idx) << 2;
		wrEn = 1'b0;
		#1;
		data = dataOut;
		@(negedge clk);
	endtask

	task automatic readCheck(string name, int idx, logic [31:0] expected);
		logic [31:0] got;
		busRead(idx, got);
		checkValue(name, expected, got);
	endtask

	function automatic logic [31:0] wordOf(logic [127:0] blk, int k);
		return blk[127 - 32*k -: 32];
	endfunction

	// go write, then poll status until done and check the timing and ciphertext
	task automatic runAndCheck(string name, logic [127:0] expCt);
		logic [31:0] st;
		int edges;
		int polls;
		busWrite(regCtrl, 32'h0000_0001, 1'b1);
		checkValue({name, " ctr after go"}, 32'd1, 32'(ctr));
		readCheck({name, " status after go"}, regCtrl, 32'h0000_0001);
		st = '0;
		edges = 0;
		polls = 0;
		while (!st[31]) begin
			edges = edgeCount - writeEdge;
			busRead(regCtrl, st);
			polls++;
			if (polls > 2 * `SEQ_DONE_COUNT) begin
				$display("%s: done never came after the go write", name);
				$display("Simulation failed");
				$fatal(1, "done missing");
			end
		end
		checkValue({name, " done edge"}, 32'(`SEQ_DONE_COUNT), 32'(edges));
		checkValue({name, " status at done"}, 32'h8000_0000, st);
		readCheck({name, " counter"}, regCount, 32'(`SEQ_DONE_COUNT));
		for (int k = 0; k < `AES_NB; k++) begin
			readCheck($sformatf("%s ct word %0d", name, k), regCt0 + k, wordOf(expCt, k));
		end
	endtask

	initial begin
		keyTab[0] = 128'h00010203_04050607_08090a0b_0c0d0e0f;
		ptTab[0] = 128'h00112233_44556677_8899aabb_ccddeeff;
		ctTab[0] = 128'h69c4e0d8_6a7b0430_d8cdb780_70b4c55a;
		keyTab[1] = 128'h2b7e1516_28aed2a6_abf71588_09cf4f3c;
		ptTab[1] = 128'h3243f6a8_885a308d_313198a2_e0370734;
		ctTab[1] = 128'h3925841d_02dc09fb_dc118597_196a0b32;
		keyTab[2] = '0;
		ptTab[2] = '0;
		ctTab[2] = 128'h66e94bd4_ef8a2c3b_884cfa59_ca342b2e;

		clk = 1'b0;
		rst_n = 1'b0;
		addr = '0;
		wrEn = 1'b0;
		accelSelect = 1'b0;
		dataIn = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// everything reads 0 out of reset
		readCheck("reset status", regCtrl, 32'h0);
		readCheck("reset counter", regCount, 32'h0);
		for (int k = 0; k < 3 * `AES_NB; k++) begin
			readCheck($sformatf("reset word %0d", regKey0 + k), regKey0 + k, 32'h0);
		end

		// readback and deselected writes
		for (int k = 0; k < `AES_NB; k++) begin
			busWrite(regKey0 + k, wordOf(keyTab[0], k), 1'b1);
			busWrite(regPt0 + k, wordOf(ptTab[0], k), 1'b1);
		end
		for (int k = 0; k < `AES_NB; k++) begin
			readCheck($sformatf("key readback %0d", k), regKey0 + k, wordOf(keyTab[0], k));
			readCheck($sformatf("pt readback %0d", k), regPt0 + k, wordOf(ptTab[0], k));
		end
		busWrite(regKey0, 32'hdead_beef, 1'b0);
		busWrite(regPt0 + 3, 32'hcafe_f00d, 1'b0);
		readCheck("deselected key write", regKey0, wordOf(keyTab[0], 0));
		readCheck("deselected pt write", regPt0 + 3, wordOf(ptTab[0], 3));

		for (int v = 0; v < NVEC; v++) begin
			for (int k = 0; k < `AES_NB; k++) begin
				busWrite(regKey0 + k, wordOf(keyTab[v], k), 1'b1);
				busWrite(regPt0 + k, wordOf(ptTab[v], k), 1'b1);
			end
			runAndCheck($sformatf("vector %0d", v), ctTab[v]);
		end

		// a second go on the same inputs restarts the run
		runAndCheck("rerun", ctTab[NVEC-1]);

		// unmapped word while status and counter are nonzero
		busWrite(3, 32'hffff_ffff, 1'b1);
		readCheck("unmapped word", 3, 32'h0);
		readCheck("status after unmapped write", regCtrl, 32'h8000_0000);

		$display("Simulation passed");
		$finish;
	end

endmodule

/* src.f */
+incdir+design
design/aesPkg.sv
design/mmioPkg.sv
design/aesMmioRegs.sv
design/aesSequencer.sv
design/aesKeySchedule.sv
design/aesRoundUnit.sv
design/aesAccelerator.sv
test/aesAcceleratorTb.sv
